// ==== include/jesd_tpl_defines.svh ====
// Link configuration for the ADC receive transport layer
// Only L=2, M=2, F=2, S=1 with 14-bit converters is verified
// Deframer index math is general, but other sets are untested
// Every source file must see the same values from this header

`ifndef JESD_TPL_DEFINES_SVH
`define JESD_TPL_DEFINES_SVH

// **************************************************
// Link configuration
// **************************************************

// Lanes delivered by the link layer
`define JESD_NUM_LANES 2
// Converter channels carried by the link
`define JESD_NUM_CHANNELS 2
// Octets per sample on the wire (F with S=1, M=L)
`define JESD_OCTETS_PER_SAMPLE 2
// Converter resolution, tail bits fill the rest of the sample
`define JESD_CONV_WIDTH 14
// Formatted output sample width after sign extension
`define JESD_SAMPLE_WIDTH 16
// Samples per converter per frame
`define JESD_SAMPLES_PER_FRAME 1
// Octets per lane in one link beat
`define JESD_OCTETS_PER_BEAT 4

// Samples per channel in one beat
`define JESD_SAMPLES_PER_BEAT \
  ((`JESD_NUM_LANES * `JESD_OCTETS_PER_BEAT) / (`JESD_NUM_CHANNELS * `JESD_OCTETS_PER_SAMPLE))
// All samples in one beat, over all channels
`define JESD_TOTAL_SAMPLES (`JESD_NUM_CHANNELS * `JESD_SAMPLES_PER_BEAT)

// **************************************************
// PN monitor
// **************************************************

// Consecutive matching beats needed to lock
`define JESD_PN_LOCK_COUNT 4
// Consecutive mismatching beats that drop lock
`define JESD_PN_LOSS_COUNT 4

`endif

// ==== rtl/jesd_tpl_pkg.sv ====
// Types shared across the transport layer
// Widths follow the link configuration in jesd_tpl_defines.svh

`include "jesd_tpl_defines.svh"

package jesd_tpl_pkg;

  // **************************************************
  // Data types
  // **************************************************

  // One beat of all lanes, lane 0 in the low bits
  typedef logic [`JESD_NUM_LANES*`JESD_OCTETS_PER_BEAT*8-1:0] link_beat_t;

  // Raw converter sample with tail bits removed
  typedef logic [`JESD_CONV_WIDTH-1:0] conv_sample_t;

  // Sample after format conversion and sign extension
  typedef logic [`JESD_SAMPLE_WIDTH-1:0] adc_sample_t;

  // One bit per converter channel
  typedef logic [`JESD_NUM_CHANNELS-1:0] chan_mask_t;

  // **************************************************
  // PN pattern
  // **************************************************

  // Lock state of one channel's PN checker
  typedef enum logic {
    PN_OOS    = 1'b0,
    PN_LOCKED = 1'b1
  } pn_state_t;

  // Feedback taps of the 14-bit pattern
  // Next value is a left shift with bit 0 fed by the XOR of these
  localparam int unsigned PN_TAP_HI = 13;
  localparam int unsigned PN_TAP_LO = 12;

endpackage

// ==== rtl/tpl_adc_deframer.sv ====
// Combinational deframer, lane octets in and converter samples out
// Assumes one sample per frame and the same lane/channel grouping as the link
// Output sample index is channel * samples_per_beat + sample, low index in low bits

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module tpl_adc_deframer (
  input  jesd_tpl_pkg::link_beat_t                             link_data,
  output jesd_tpl_pkg::conv_sample_t [`JESD_TOTAL_SAMPLES-1:0] conv_data
);

  import jesd_tpl_pkg::*;

  // Sample width on the wire, tail bits included
  localparam int BITS_PER_SAMPLE = `JESD_OCTETS_PER_SAMPLE * 8;
  // Bits that one lane carries for one frame
  localparam int BITS_PER_FRAME = BITS_PER_SAMPLE * `JESD_SAMPLES_PER_FRAME *
                                  `JESD_NUM_CHANNELS / `JESD_NUM_LANES;
  localparam int FRAMES_PER_BEAT = `JESD_OCTETS_PER_BEAT * 8 / BITS_PER_FRAME;
  localparam int TOTAL_BITS = $bits(link_beat_t);
  // One channel's share of a frame
  localparam int CHAN_BITS = `JESD_SAMPLES_PER_FRAME * BITS_PER_SAMPLE;

  // Intermediate views, all with the first octet at the top
  link_beat_t octet_msb;
  link_beat_t frame_msb;
  link_beat_t chan_msb;

  // **************************************************
  // Octet order
  // **************************************************

  // First octet on the wire ends up most significant
  for (genvar o = 0; o < TOTAL_BITS / 8; o++) begin : g_octet
    assign octet_msb[TOTAL_BITS-1-o*8 -: 8] = link_data[o*8 +: 8];
  end

  // **************************************************
  // Frame grouping
  // **************************************************

  // Interleave lanes so each frame is contiguous over all lanes
  for (genvar f = 0; f < FRAMES_PER_BEAT; f++) begin : g_frame
    for (genvar l = 0; l < `JESD_NUM_LANES; l++) begin : g_lane
      assign frame_msb[(l + f*`JESD_NUM_LANES)*BITS_PER_FRAME +: BITS_PER_FRAME] =
        octet_msb[(f + l*FRAMES_PER_BEAT)*BITS_PER_FRAME +: BITS_PER_FRAME];
    end
  end

  // **************************************************
  // Channel grouping
  // **************************************************

  // Collect each channel's samples from all frames side by side
  for (genvar c = 0; c < `JESD_NUM_CHANNELS; c++) begin : g_chan
    for (genvar f = 0; f < FRAMES_PER_BEAT; f++) begin : g_frame
      assign chan_msb[(f + c*FRAMES_PER_BEAT)*CHAN_BITS +: CHAN_BITS] =
        frame_msb[(c + f*`JESD_NUM_CHANNELS)*CHAN_BITS +: CHAN_BITS];
    end
  end

  // Back to low-index-first sample order
  // Top bits of each sample are the converter data, the tail is dropped
  for (genvar s = 0; s < `JESD_TOTAL_SAMPLES; s++) begin : g_sample
    assign conv_data[s] = chan_msb[TOTAL_BITS-1-s*BITS_PER_SAMPLE -: `JESD_CONV_WIDTH];
  end

endmodule

// ==== rtl/tpl_adc_data_format.sv ====
// Sample formatter, one register stage
// fmt_twos is a level and is sampled together with each valid beat
// Output data holds its last value between valid beats

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module tpl_adc_data_format (
  input  logic                                                 link_clk,
  input  logic                                                 rst,
  input  jesd_tpl_pkg::conv_sample_t [`JESD_TOTAL_SAMPLES-1:0] conv_data,
  input  logic                                                 conv_valid,
  input  logic                                                 fmt_twos,
  output jesd_tpl_pkg::adc_sample_t [`JESD_TOTAL_SAMPLES-1:0]  fmt_data,
  output logic                                                 fmt_valid
);

  import jesd_tpl_pkg::*;

  localparam int MSB = `JESD_CONV_WIDTH - 1;
  // Number of sign bits added on top
  localparam int EXT = `JESD_SAMPLE_WIDTH - `JESD_CONV_WIDTH;

  adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] fmt_next;

  // **************************************************
  // Per-sample conversion
  // **************************************************

  for (genvar i = 0; i < `JESD_TOTAL_SAMPLES; i++) begin : g_sample
    conv_sample_t twos;

    // Offset binary becomes two's complement by flipping the MSB
    assign twos = {conv_data[i][MSB] ^ fmt_twos, conv_data[i][MSB-1:0]};
    // Sign extend from the converter MSB
    assign fmt_next[i] = {{EXT{twos[MSB]}}, twos};
  end

  // **************************************************
  // Output register
  // **************************************************

  // Valid follows the input strobe by one cycle
  always_ff @(posedge link_clk) begin
    if (rst) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= conv_valid;
    end
  end

  // Data only loads on valid beats
  always_ff @(posedge link_clk) begin
    if (conv_valid) begin
      fmt_data <= fmt_next;
    end
  end

endmodule

// ==== rtl/tpl_adc_pn_monitor.sv ====
// Per-channel PN checker for the 14-bit test pattern
// Self-synchronizing, each beat is checked against the last sample of the previous beat
// Samples of a channel are assumed in time order, lowest index first
// pn_clear is a one-cycle pulse and wins over an error in the same cycle

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module tpl_adc_pn_monitor (
  input  logic                                                 link_clk,
  input  logic                                                 rst,
  input  jesd_tpl_pkg::conv_sample_t [`JESD_TOTAL_SAMPLES-1:0] conv_data,
  input  logic                                                 conv_valid,
  input  logic                                                 pn_clear,
  output jesd_tpl_pkg::chan_mask_t                             pn_state,
  output jesd_tpl_pkg::chan_mask_t                             pn_err_raw
);

  import jesd_tpl_pkg::*;

  localparam int SPB = `JESD_SAMPLES_PER_BEAT;
  // Counter must reach the larger of the two thresholds
  localparam int CNT_MAX = (`JESD_PN_LOCK_COUNT > `JESD_PN_LOSS_COUNT) ?
                           `JESD_PN_LOCK_COUNT : `JESD_PN_LOSS_COUNT;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  typedef logic [CNT_W-1:0] pn_cnt_t;

  // One step of the pattern generator
  function automatic conv_sample_t pn_next(input conv_sample_t v);
    pn_next = {v[`JESD_CONV_WIDTH-2:0], v[PN_TAP_HI] ^ v[PN_TAP_LO]};
  endfunction

  for (genvar c = 0; c < `JESD_NUM_CHANNELS; c++) begin : g_chan
    conv_sample_t prev_q;
    logic         seeded_q;
    pn_cnt_t      lock_cnt_q;
    pn_cnt_t      loss_cnt_q;
    pn_state_t    state_q;
    logic         err_q;
    logic         match;

    // **************************************************
    // Pattern compare
    // **************************************************

    // First sample continues from the previous beat, the rest chain inside the beat
    always_comb begin
      match = (conv_data[c*SPB] == pn_next(prev_q));
      for (int k = 1; k < SPB; k++) begin
        if (conv_data[c*SPB+k] != pn_next(conv_data[c*SPB+k-1])) begin
          match = 1'b0;
        end
      end
    end

    // Last sample of the beat seeds the next compare
    always_ff @(posedge link_clk) begin
      if (conv_valid) begin
        prev_q <= conv_data[c*SPB+SPB-1];
      end
    end

    // **************************************************
    // Lock FSM
    // **************************************************

    always_ff @(posedge link_clk) begin
      if (rst) begin
        seeded_q   <= 1'b0;
        lock_cnt_q <= '0;
        loss_cnt_q <= '0;
        state_q    <= PN_OOS;
      end else if (conv_valid) begin
        if (!seeded_q) begin
          // Seed beat, nothing to compare against yet
          seeded_q <= 1'b1;
        end else if (match) begin
          loss_cnt_q <= '0;
          if (state_q == PN_OOS) begin
            if (lock_cnt_q == pn_cnt_t'(`JESD_PN_LOCK_COUNT - 1)) begin
              state_q    <= PN_LOCKED;
              lock_cnt_q <= '0;
            end else begin
              lock_cnt_q <= lock_cnt_q + pn_cnt_t'(1);
            end
          end
        end else begin
          lock_cnt_q <= '0;
          if (state_q == PN_LOCKED) begin
            if (loss_cnt_q == pn_cnt_t'(`JESD_PN_LOSS_COUNT - 1)) begin
              // Lost sync, next valid beat reseeds
              state_q    <= PN_OOS;
              loss_cnt_q <= '0;
              seeded_q   <= 1'b0;
            end else begin
              loss_cnt_q <= loss_cnt_q + pn_cnt_t'(1);
            end
          end
        end
      end
    end

    // Sticky error, only raised while locked
    always_ff @(posedge link_clk) begin
      if (rst || pn_clear) begin
        err_q <= 1'b0;
      end else if (conv_valid && seeded_q && !match && (state_q == PN_LOCKED)) begin
        err_q <= 1'b1;
      end
    end

    assign pn_state[c]   = (state_q == PN_LOCKED);
    assign pn_err_raw[c] = err_q;
  end

endmodule

// ==== rtl/tpl_adc_channel_out.sv ====
// Channel output stage, one register stage after formatter and PN monitor
// chan_enable is a level sampled every cycle, masking data and status
// While in reset every enabled channel reports out of sync

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module tpl_adc_channel_out (
  input  logic                                                link_clk,
  input  logic                                                rst,
  input  jesd_tpl_pkg::adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] fmt_data,
  input  logic                                                fmt_valid,
  input  jesd_tpl_pkg::chan_mask_t                            pn_state,
  input  jesd_tpl_pkg::chan_mask_t                            pn_err_raw,
  input  jesd_tpl_pkg::chan_mask_t                            chan_enable,
  output jesd_tpl_pkg::adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] adc_data,
  output logic                                                adc_valid,
  output jesd_tpl_pkg::chan_mask_t                            pn_oos,
  output jesd_tpl_pkg::chan_mask_t                            pn_err
);

  import jesd_tpl_pkg::*;

  localparam int SPB = `JESD_SAMPLES_PER_BEAT;

  adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] data_masked;

  // **************************************************
  // Channel mask
  // **************************************************

  // Each sample belongs to the channel at index / samples per beat
  for (genvar i = 0; i < `JESD_TOTAL_SAMPLES; i++) begin : g_mask
    assign data_masked[i] = chan_enable[i / SPB] ? fmt_data[i] : '0;
  end

  // **************************************************
  // Output registers
  // **************************************************

  always_ff @(posedge link_clk) begin
    if (rst) begin
      adc_valid <= 1'b0;
      adc_data  <= '0;
      pn_oos    <= chan_enable;
      pn_err    <= '0;
    end else begin
      adc_valid <= fmt_valid;
      // Data holds between beats
      if (fmt_valid) begin
        adc_data <= data_masked;
      end
      // Monitor reports lock, the output reports out of sync
      pn_oos <= chan_enable & ~pn_state;
      pn_err <= chan_enable & pn_err_raw;
    end
  end

endmodule

// ==== rtl/jesd_tpl_adc.sv ====
// JESD204 ADC receive transport layer, top level
// adc_valid follows link_valid by 2 cycles, with PN status for the same beat
// No back-pressure, the consumer must take every adc_valid beat

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module jesd_tpl_adc (
  input  logic                                                link_clk,
  input  logic                                                rst,
  input  jesd_tpl_pkg::link_beat_t                            link_data,
  input  logic                                                link_valid,
  input  logic                                                fmt_twos,
  input  jesd_tpl_pkg::chan_mask_t                            chan_enable,
  input  logic                                                pn_clear,
  output jesd_tpl_pkg::adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] adc_data,
  output logic                                                adc_valid,
  output jesd_tpl_pkg::chan_mask_t                            pn_oos,
  output jesd_tpl_pkg::chan_mask_t                            pn_err
);

  import jesd_tpl_pkg::*;

  // Deframed samples, valid in the link_valid cycle
  conv_sample_t [`JESD_TOTAL_SAMPLES-1:0] conv_data;
  // Formatter and monitor results, one cycle later
  adc_sample_t [`JESD_TOTAL_SAMPLES-1:0]  fmt_data;
  logic                                   fmt_valid;
  chan_mask_t                             pn_state;
  chan_mask_t                             pn_err_raw;

  tpl_adc_deframer deframer_i (
    .link_data (link_data),
    .conv_data (conv_data)
  );

  // Formatter and PN monitor run side by side on the same beat
  tpl_adc_data_format data_format_i (
    .link_clk   (link_clk),
    .rst        (rst),
    .conv_data  (conv_data),
    .conv_valid (link_valid),
    .fmt_twos   (fmt_twos),
    .fmt_data   (fmt_data),
    .fmt_valid  (fmt_valid)
  );

  tpl_adc_pn_monitor pn_monitor_i (
    .link_clk   (link_clk),
    .rst        (rst),
    .conv_data  (conv_data),
    .conv_valid (link_valid),
    .pn_clear   (pn_clear),
    .pn_state   (pn_state),
    .pn_err_raw (pn_err_raw)
  );

  tpl_adc_channel_out channel_out_i (
    .link_clk    (link_clk),
    .rst         (rst),
    .fmt_data    (fmt_data),
    .fmt_valid   (fmt_valid),
    .pn_state    (pn_state),
    .pn_err_raw  (pn_err_raw),
    .chan_enable (chan_enable),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .pn_oos      (pn_oos),
    .pn_err      (pn_err)
  );

endmodule

// ==== tests/jesd_tpl_adc_checker.sv ====
// Concurrent assertions on the top level ports, bound to jesd_tpl_adc
// The simulator must not stop on the first $error for fail_count to be read

`timescale 1ns/1ps

module jesd_tpl_adc_checker (
  input logic                     link_clk,
  input logic                     rst,
  input logic                     link_valid,
  input logic                     adc_valid,
  input jesd_tpl_pkg::chan_mask_t chan_enable,
  input jesd_tpl_pkg::chan_mask_t pn_err
);

  // Failed assertions so far, read by the testbench at the end
  int fail_count = 0;

  // No output beat in reset or on the cycle after
  assert property (@(posedge link_clk) ($past(rst) || $past(rst, 2)) |-> !adc_valid)
    else begin
      $error("adc_valid high during or right after reset");
      fail_count++;
    end

  // Fixed two-cycle latency, every beat comes out once
  assert property (@(posedge link_clk) disable iff (rst) adc_valid == $past(link_valid, 2))
    else begin
      $error("adc_valid does not follow link_valid by 2 cycles");
      fail_count++;
    end

  // Status register uses the enable of the previous edge
  assert property (@(posedge link_clk) disable iff (rst) (pn_err & ~$past(chan_enable)) == '0)
    else begin
      $error("pn_err set on a disabled channel");
      fail_count++;
    end

endmodule

bind jesd_tpl_adc jesd_tpl_adc_checker checker_i (
  .link_clk    (link_clk),
  .rst         (rst),
  .link_valid  (link_valid),
  .adc_valid   (adc_valid),
  .chan_enable (chan_enable),
  .pn_err      (pn_err)
);

// ==== tests/tb_jesd_tpl_adc.sv ====
// Self-checking testbench for the ADC transport layer top level
// Beats come from a fixed-seed LCG, expected beats from a model queue
// Assertion failures of the bound checker also fail the run

`timescale 1ns/1ps

`include "jesd_tpl_defines.svh"

module tb_jesd_tpl_adc;

  import jesd_tpl_pkg::*;

  localparam int NCH = `JESD_NUM_CHANNELS;
  localparam int SPB = `JESD_SAMPLES_PER_BEAT;
  localparam int LANE_BITS = `JESD_OCTETS_PER_BEAT * 8;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_GAP = 3;
  // Beats of tests 1 to 3, then pattern beats and the pn_clear cycle of tests 4 to 6
  localparam int RANDOM_BEATS = 400;
  localparam int PN_CYCLES = 20;
  localparam int DRAIN_CYCLES = 4;
  localparam int TIMEOUT_CYCLES =
    (RANDOM_BEATS * (MAX_GAP + 1) + PN_CYCLES + 8 * DRAIN_CYCLES) * 2 + RESET_CYCLES;

  typedef adc_sample_t [`JESD_TOTAL_SAMPLES-1:0] beat_samples_t;

  logic          link_clk;
  logic          rst;
  link_beat_t    link_data;
  logic          link_valid;
  logic          fmt_twos;
  chan_mask_t    chan_enable;
  logic          pn_clear;
  beat_samples_t adc_data;
  logic          adc_valid;
  chan_mask_t    pn_oos;
  chan_mask_t    pn_err;

  // Model state per channel
  conv_sample_t  m_prev [NCH];
  logic          m_seeded [NCH];
  logic          m_locked [NCH];
  logic          m_err [NCH];
  int            m_lock_cnt [NCH];
  int            m_loss_cnt [NCH];
  // Expected beats in arrival order, unmasked
  beat_samples_t exp_data_q [$];
  chan_mask_t    exp_lock_q [$];
  chan_mask_t    exp_err_q [$];

  logic [31:0]   lcg_state;
  conv_sample_t  pn_gen;
  chan_mask_t    en_at_edge;
  chan_mask_t    last_oos;
  chan_mask_t    last_err;
  int            errors;
  int            in_beats;
  int            out_beats;
  int            cycles;

  jesd_tpl_adc jesd_tpl_adc_i (
    .link_clk    (link_clk),
    .rst         (rst),
    .link_data   (link_data),
    .link_valid  (link_valid),
    .fmt_twos    (fmt_twos),
    .chan_enable (chan_enable),
    .pn_clear    (pn_clear),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .pn_oos      (pn_oos),
    .pn_err      (pn_err)
  );

  initial begin
    link_clk = 1'b0;
    forever #50 link_clk = ~link_clk;
  end

  // **************************************************
  // Stimulus helpers
  // **************************************************

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Shift left, bit 0 gets bit 13 xor bit 12
  function automatic conv_sample_t pn_step(input conv_sample_t v);
    return {v[12:0], v[13] ^ v[12]};
  endfunction

  // Lane c octet 2s is the upper byte, the low 2 bits are tail
  function automatic conv_sample_t frame_sample(input link_beat_t beat, input int c,
                                                input int s);
    logic [15:0] w;
    w = {beat[LANE_BITS*c+16*s +: 8], beat[LANE_BITS*c+16*s+8 +: 8]};
    return w[15:2];
  endfunction

  function automatic adc_sample_t format_sample(input conv_sample_t v, input logic twos);
    logic b13;
    b13 = v[13] ^ twos;
    return {{2{b13}}, b13, v[12:0]};
  endfunction

  // One lane word for two samples, first octet holds the upper byte of s0
  function automatic logic [31:0] lane_word(input conv_sample_t s0, input conv_sample_t s1,
                                            input logic [3:0] tails);
    logic [15:0] w0;
    logic [15:0] w1;
    w0 = {s0, tails[1:0]};
    w1 = {s1, tails[3:2]};
    return {w1[7:0], w1[15:8], w0[7:0], w0[15:8]};
  endfunction

  function automatic void flag_mismatch(input string name, input logic [63:0] got,
                                        input logic [63:0] want);
    errors++;
    $display("mismatch %s got %h expected %h", name, got, want);
  endfunction

  // Drive one cycle and advance the model with what the DUT will capture
  task automatic step(input logic valid, input link_beat_t beat, input logic twos,
                      input chan_mask_t en, input logic clear);
    conv_sample_t  s0;
    conv_sample_t  s1;
    logic          hit;
    logic          bad;
    beat_samples_t want;
    chan_mask_t    lock_v;
    chan_mask_t    err_v;
    @(posedge link_clk);
    #1;
    link_valid = valid;
    link_data = beat;
    fmt_twos = twos;
    chan_enable = en;
    pn_clear = clear;
    for (int c = 0; c < NCH; c++) begin
      bad = 1'b0;
      if (valid) begin
        s0 = frame_sample(beat, c, 0);
        s1 = frame_sample(beat, c, 1);
        for (int s = 0; s < SPB; s++) begin
          want[c*SPB+s] = format_sample(frame_sample(beat, c, s), twos);
        end
        if (!m_seeded[c]) begin
          m_seeded[c] = 1'b1;
        end else begin
          hit = (s0 == pn_step(m_prev[c])) && (s1 == pn_step(s0));
          bad = !hit && m_locked[c];
          if (hit) begin
            m_loss_cnt[c] = 0;
            if (!m_locked[c]) begin
              m_lock_cnt[c]++;
              if (m_lock_cnt[c] == `JESD_PN_LOCK_COUNT) begin
                m_locked[c] = 1'b1;
                m_lock_cnt[c] = 0;
              end
            end
          end else begin
            m_lock_cnt[c] = 0;
            if (m_locked[c]) begin
              m_loss_cnt[c]++;
              // Dropping lock means the next beat only reseeds
              if (m_loss_cnt[c] == `JESD_PN_LOSS_COUNT) begin
                m_locked[c] = 1'b0;
                m_loss_cnt[c] = 0;
                m_seeded[c] = 1'b0;
              end
            end
          end
        end
        m_prev[c] = s1;
      end
      if (clear) begin
        m_err[c] = 1'b0;
      end else if (bad) begin
        m_err[c] = 1'b1;
      end
      lock_v[c] = m_locked[c];
      err_v[c] = m_err[c];
    end
    if (valid) begin
      exp_data_q.push_back(want);
      exp_lock_q.push_back(lock_v);
      exp_err_q.push_back(err_v);
      in_beats++;
    end
  endtask

  // Random beats after 0 to 3 idle cycles each
  task automatic random_beats(input int n, input logic twos_fixed, input logic rand_en);
    logic [31:0] r;
    logic        twos;
    chan_mask_t  en;
    int          gap;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      gap = int'(r[1:0]);
      twos = rand_en ? r[8] : twos_fixed;
      en = rand_en ? r[5:4] : 2'b11;
      for (int g = 0; g < gap; g++) begin
        step(1'b0, {next_rand(), next_rand()}, twos, en, 1'b0);
      end
      step(1'b1, {next_rand(), next_rand()}, twos, en, 1'b0);
    end
  endtask

  // Channel 0 carries the pattern, channel 1 random data
  task automatic pn_beat(input logic corrupt, input chan_mask_t en);
    conv_sample_t s0;
    conv_sample_t s1;
    logic [31:0]  r;
    s0 = pn_step(pn_gen);
    s1 = pn_step(s0);
    pn_gen = s1;
    r = next_rand();
    // Flipped LSB breaks this beat and the next beat's first compare
    if (corrupt) begin
      s1 = s1 ^ 14'h1;
    end
    step(1'b1, {next_rand(), lane_word(s0, s1, r[3:0])}, 1'b0, en, 1'b0);
  endtask

  // Idle until all expected beats came out, bounded by the pipeline depth
  task automatic drain();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < DRAIN_CYCLES) begin
      step(1'b0, '0, fmt_twos, chan_enable, 1'b0);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("%0d expected beats never appeared on adc_valid", exp_data_q.size());
      exp_data_q.delete();
      exp_lock_q.delete();
      exp_err_q.delete();
    end
  endtask

  task automatic print_test_result(input int num, input string name, input int base);
    $display("test %0d %s: %0d errors", num, name, errors - base);
  endtask

  // **************************************************
  // Output monitor
  // **************************************************

  // Enable as the output stage captured it
  always @(posedge link_clk) begin
    en_at_edge <= chan_enable;
  end

  task automatic check_beat();
    beat_samples_t d;
    chan_mask_t    lk;
    chan_mask_t    er;
    adc_sample_t   want;
    if (exp_data_q.size() == 0) begin
      errors++;
      $display("adc_valid high with no beat outstanding");
    end else begin
      d = exp_data_q.pop_front();
      lk = exp_lock_q.pop_front();
      er = exp_err_q.pop_front();
      out_beats++;
      for (int i = 0; i < `JESD_TOTAL_SAMPLES; i++) begin
        want = en_at_edge[i / SPB] ? d[i] : '0;
        if (adc_data[i] !== want)
          flag_mismatch($sformatf("adc_data[%0d]", i), 64'(adc_data[i]), 64'(want));
      end
      if (pn_oos !== (en_at_edge & ~lk))
        flag_mismatch("pn_oos", 64'(pn_oos), 64'(en_at_edge & ~lk));
      if (pn_err !== (en_at_edge & er))
        flag_mismatch("pn_err", 64'(pn_err), 64'(en_at_edge & er));
      last_oos = pn_oos;
      last_err = pn_err;
    end
  endtask

  // Sampled mid-cycle, away from the updating edge
  always @(negedge link_clk) begin
    if (!rst && adc_valid) begin
      check_beat();
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge link_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycles);
    $display("Test failed");
    $finish;
  end

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    int          base;
    logic [31:0] r;
    link_valid = 1'b0;
    link_data = '0;
    fmt_twos = 1'b0;
    chan_enable = 2'b11;
    pn_clear = 1'b0;
    rst = 1'b1;
    lcg_state = 32'h4a88_055a;
    errors = 0;
    in_beats = 0;
    out_beats = 0;
    for (int c = 0; c < NCH; c++) begin
      m_prev[c] = '0;
      m_seeded[c] = 1'b0;
      m_locked[c] = 1'b0;
      m_err[c] = 1'b0;
      m_lock_cnt[c] = 0;
      m_loss_cnt[c] = 0;
    end
    repeat (RESET_CYCLES) @(posedge link_clk);
    #1;
    rst = 1'b0;
    // Reset values, enabled channels start out of sync
    if (adc_valid !== 1'b0)
      flag_mismatch("adc_valid", 64'(adc_valid), 64'(0));
    if (adc_data !== '0)
      flag_mismatch("adc_data", 64'(adc_data), 64'(0));
    if (pn_oos !== chan_enable)
      flag_mismatch("pn_oos", 64'(pn_oos), 64'(chan_enable));
    if (pn_err !== 2'b00)
      flag_mismatch("pn_err", 64'(pn_err), 64'(2'b00));

    base = errors;
    random_beats(200, 1'b0, 1'b0);
    drain();
    if (out_beats != in_beats) begin
      errors++;
      $display("%0d adc_valid beats for %0d link_valid beats", out_beats, in_beats);
    end
    print_test_result(1, "deframe mapping", base);

    base = errors;
    random_beats(100, 1'b1, 1'b0);
    drain();
    print_test_result(2, "format", base);

    base = errors;
    random_beats(100, 1'b0, 1'b1);
    drain();
    print_test_result(3, "channel masking", base);

    base = errors;
    r = next_rand();
    pn_gen = r[13:0] | 14'h1;
    repeat (8) pn_beat(1'b0, 2'b11);
    drain();
    if (last_oos !== 2'b10)
      flag_mismatch("pn_oos", 64'(last_oos), 64'(2'b10));
    print_test_result(4, "pn lock", base);

    base = errors;
    pn_beat(1'b1, 2'b11);
    repeat (3) pn_beat(1'b0, 2'b11);
    drain();
    // Error is sticky while lock is held
    if (last_err !== 2'b01)
      flag_mismatch("pn_err", 64'(last_err), 64'(2'b01));
    if (last_oos !== 2'b10)
      flag_mismatch("pn_oos", 64'(last_oos), 64'(2'b10));
    // Channel 0 disabled hides its sticky error
    pn_beat(1'b0, 2'b10);
    drain();
    if (last_err !== 2'b00)
      flag_mismatch("pn_err", 64'(last_err), 64'(2'b00));
    step(1'b0, '0, 1'b0, 2'b11, 1'b1);
    repeat (2) pn_beat(1'b0, 2'b11);
    drain();
    if (last_err !== 2'b00)
      flag_mismatch("pn_err", 64'(last_err), 64'(2'b00));
    print_test_result(5, "error and clear", base);

    base = errors;
    repeat (4) pn_beat(1'b1, 2'b11);
    drain();
    if (last_oos !== 2'b11)
      flag_mismatch("pn_oos", 64'(last_oos), 64'(2'b11));
    print_test_result(6, "loss of sync", base);

    $display("%0d link beats, %0d output beats, %0d errors, %0d assertion failures",
             in_beats, out_beats, errors, jesd_tpl_adc_i.checker_i.fail_count);
    if (errors == 0 && jesd_tpl_adc_i.checker_i.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
rtl/jesd_tpl_pkg.sv
rtl/tpl_adc_deframer.sv
rtl/tpl_adc_data_format.sv
rtl/tpl_adc_pn_monitor.sv
rtl/tpl_adc_channel_out.sv
rtl/jesd_tpl_adc.sv
tests/jesd_tpl_adc_checker.sv
tests/tb_jesd_tpl_adc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run, success only when the pass message appears
# The error limit keeps the run going after an assertion failure

verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
  --top-module tb_jesd_tpl_adc -o sim_tb &&
./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr |
  grep -x "Test passed" > /dev/null &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }
